// ==== build.f ====
mem_pkg.sv
mem_req_if.sv
dual_port_lutram.sv
fifo_queue.sv
request_arbiter.sv
shared_memory_unit.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

// ==== dual_port_lutram.sv ====
`timescale 1ns/1ps

module dual_port_lutram
    import mem_pkg::*;
#(
    parameter int ENTRY_WIDTH = DATA_WIDTH,
    parameter int NUM_SET     = MEM_DEPTH
)
(
    input  logic                              clk_in,
    input  logic                              reset_in,

    input  logic [mask_len(ENTRY_WIDTH)-1:0]  write_en,
    input  logic [$clog2(NUM_SET)-1:0]        write_addr,
    input  logic [ENTRY_WIDTH-1:0]            write_data,

    input  logic [$clog2(NUM_SET)-1:0]        read_addr,
    output logic [ENTRY_WIDTH-1:0]            read_data
);

    logic [ENTRY_WIDTH-1:0] ram [NUM_SET];

    // byte lanes, each bit follows the enable of its byte
    always_ff @(posedge clk_in)
    begin
        for (int i = 0; i < ENTRY_WIDTH; i++)
        begin
            if (write_en[i / BYTE_LEN])
            begin
                ram[write_addr][i] <= write_data[i];
            end
        end
    end

    // async read, old data on a same-cycle write to the same set
    assign read_data = ram[read_addr];

    // callers only ever write whole words
    whole_word_write: assert property (
        @(posedge clk_in) disable iff (reset_in)
        (write_en == '0) || (&write_en)
    )
    else
    begin
        $error("dual_port_lutram: partial write mask %b", write_en);
    end

endmodule

// ==== fifo_queue.sv ====
`timescale 1ns/1ps

module fifo_queue
    import mem_pkg::*;
#(
    parameter int ENTRY_WIDTH  = REQ_WIDTH,
    // power of two, at least 2
    parameter int QUEUE_SIZE   = QUEUE_DEPTH,
    // "LUTRAM" or "FlipFlop"
    parameter     STORAGE_TYPE = "LUTRAM"
)
(
    input  logic                    clk_in,
    input  logic                    reset_in,

    output logic                    is_empty,
    output logic                    is_full,

    input  logic [ENTRY_WIDTH-1:0]  request,
    input  logic                    request_valid_in,
    output logic                    issue_ack_out,

    output logic [ENTRY_WIDTH-1:0]  request_out,
    output logic                    request_valid_out,
    input  logic                    issue_ack_in
);

    localparam int PTR_WIDTH = $clog2(QUEUE_SIZE);

    logic [QUEUE_SIZE-1:0]   entry_valid;
    logic [PTR_WIDTH-1:0]    write_ptr;
    logic [PTR_WIDTH-1:0]    read_ptr;
    logic [PTR_WIDTH-1:0]    load_ptr;
    logic [ENTRY_WIDTH-1:0]  storage_data;
    logic                    consume;
    logic                    write_accept;
    logic                    head_load;

    assign is_full  = &entry_valid;
    assign is_empty = ~|entry_valid;

    assign consume       = request_valid_out & issue_ack_in;
    // full queue still takes a write when its head leaves this cycle
    assign issue_ack_out = ~is_full | consume;
    assign write_accept  = request_valid_in & issue_ack_out;

    // look ahead past a head that is leaving
    assign load_ptr  = consume ? read_ptr + 1'b1 : read_ptr;
    assign head_load = ~request_valid_out | consume;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            entry_valid <= '0;
            write_ptr   <= '0;
            read_ptr    <= '0;
        end
        else
        begin
            if (consume)
            begin
                entry_valid[read_ptr] <= 1'b0;
                read_ptr              <= read_ptr + 1'b1;
            end
            // set wins over clear when a full queue swaps its head slot
            if (write_accept)
            begin
                entry_valid[write_ptr] <= 1'b1;
                write_ptr              <= write_ptr + 1'b1;
            end
        end
    end

    // head register fed straight from the async storage read,
    // so a write into an empty queue is presented one edge later
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            request_valid_out <= 1'b0;
        end
        else if (head_load)
        begin
            request_valid_out <= entry_valid[load_ptr];
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (head_load && entry_valid[load_ptr])
        begin
            request_out <= storage_data;
        end
    end

    generate
        if (STORAGE_TYPE == "LUTRAM")
        begin : g_lutram
            localparam int MASK_LEN = mask_len(ENTRY_WIDTH);

            dual_port_lutram
            #(
                .ENTRY_WIDTH (ENTRY_WIDTH),
                .NUM_SET     (QUEUE_SIZE)
            )
            entry_ram
            (
                .clk_in      (clk_in),
                .reset_in    (reset_in),
                .write_en    ({MASK_LEN{write_accept}}),
                .write_addr  (write_ptr),
                .write_data  (request),
                .read_addr   (load_ptr),
                .read_data   (storage_data)
            );
        end
        else
        begin : g_flipflop
            logic [ENTRY_WIDTH-1:0] entry_reg [QUEUE_SIZE];

            always_ff @(posedge clk_in)
            begin
                if (write_accept)
                begin
                    entry_reg[write_ptr] <= request;
                end
            end

            assign storage_data = entry_reg[load_ptr];
        end
    endgenerate

    // a write lands on a free slot or on the head slot leaving this cycle
    write_slot_free: assert property (
        @(posedge clk_in) disable iff (reset_in)
        write_accept |-> (!entry_valid[write_ptr] || (consume && (write_ptr == read_ptr)))
    )
    else
    begin
        $error("fifo_queue: write over a live entry");
    end

    head_stable: assert property (
        @(posedge clk_in) disable iff (reset_in)
        (request_valid_out && !issue_ack_in) |=> (request_valid_out && $stable(request_out))
    )
    else
    begin
        $error("fifo_queue: head changed before it was consumed");
    end

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

    localparam int DATA_WIDTH  = 32;
    localparam int ADDR_WIDTH  = 8;
    localparam int MEM_DEPTH   = 256;
    localparam int BYTE_LEN    = 8;
    // power of two
    localparam int QUEUE_DEPTH = 4;
    localparam int NUM_PORTS   = 2;

    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_opcode_e;

    // also the port tag carried on responses
    typedef enum logic
    {
        GRANT_PORT0 = 1'b0,
        GRANT_PORT1 = 1'b1
    } grant_e;

    typedef struct packed
    {
        mem_opcode_e            opcode;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [DATA_WIDTH-1:0]  data;
    } mem_req_t;

    localparam int REQ_WIDTH = $bits(mem_req_t);

    // byte enables to cover a word, top byte may be partial
    function automatic int mask_len(input int width);
        return (width + BYTE_LEN - 1) / BYTE_LEN;
    endfunction

endpackage

// ==== mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if
    import mem_pkg::*;
();

    logic                   valid;
    mem_opcode_e            opcode;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [DATA_WIDTH-1:0]  data;
    grant_e                 port;

    // arbiter side
    modport arb
    (
        output valid,
        output opcode,
        output addr,
        output data,
        output port
    );

    // memory always accepts, no ready back
    modport mem
    (
        input  valid,
        input  opcode,
        input  addr,
        input  data,
        input  port
    );

endinterface

// ==== mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top
    import mem_pkg::*;
(
    input  logic                   clk_in,
    input  logic                   reset_in,

    input  logic                   req_valid_0,
    input  mem_opcode_e            req_opcode_0,
    input  logic [ADDR_WIDTH-1:0]  req_addr_0,
    input  logic [DATA_WIDTH-1:0]  req_data_0,
    output logic                   req_ack_0,

    input  logic                   req_valid_1,
    input  mem_opcode_e            req_opcode_1,
    input  logic [ADDR_WIDTH-1:0]  req_addr_1,
    input  logic [DATA_WIDTH-1:0]  req_data_1,
    output logic                   req_ack_1,

    input  logic                   mem_hold,

    output logic                   resp_valid,
    output grant_e                 resp_port,
    output logic [DATA_WIDTH-1:0]  resp_data
);

    mem_req_t  req0;
    mem_req_t  req1;
    mem_req_t  head0;
    mem_req_t  head1;
    logic      head_valid0;
    logic      head_valid1;
    logic      issue_ack0;
    logic      issue_ack1;

    mem_req_if grant_bus ();

    assign req0 = '{opcode: req_opcode_0, addr: req_addr_0, data: req_data_0};
    assign req1 = '{opcode: req_opcode_1, addr: req_addr_1, data: req_data_1};

    fifo_queue
    #(
        .ENTRY_WIDTH        (REQ_WIDTH),
        .QUEUE_SIZE         (QUEUE_DEPTH),
        .STORAGE_TYPE       ("LUTRAM")
    )
    port0_queue
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .is_empty           (),
        .is_full            (),
        .request            (req0),
        .request_valid_in   (req_valid_0),
        .issue_ack_out      (req_ack_0),
        .request_out        (head0),
        .request_valid_out  (head_valid0),
        .issue_ack_in       (issue_ack0)
    );

    // flip-flop storage on port 1
    fifo_queue
    #(
        .ENTRY_WIDTH        (REQ_WIDTH),
        .QUEUE_SIZE         (QUEUE_DEPTH),
        .STORAGE_TYPE       ("FlipFlop")
    )
    port1_queue
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .is_empty           (),
        .is_full            (),
        .request            (req1),
        .request_valid_in   (req_valid_1),
        .issue_ack_out      (req_ack_1),
        .request_out        (head1),
        .request_valid_out  (head_valid1),
        .issue_ack_in       (issue_ack1)
    );

    request_arbiter arbiter
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .head0        (head0),
        .head1        (head1),
        .head_valid0  (head_valid0),
        .head_valid1  (head_valid1),
        .issue_ack0   (issue_ack0),
        .issue_ack1   (issue_ack1),
        .mem_hold     (mem_hold),
        .grant_bus    (grant_bus.arb)
    );

    shared_memory_unit memory_unit
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .grant_bus    (grant_bus.mem),
        .resp_valid   (resp_valid),
        .resp_port    (resp_port),
        .resp_data    (resp_data)
    );

endmodule

// ==== request_arbiter.sv ====
`timescale 1ns/1ps

module request_arbiter
    import mem_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset_in,

    input  mem_req_t  head0,
    input  mem_req_t  head1,
    input  logic      head_valid0,
    input  logic      head_valid1,
    output logic      issue_ack0,
    output logic      issue_ack1,

    input  logic      mem_hold,
    mem_req_if.arb    grant_bus
);

    grant_e                last_winner;
    grant_e                winner;
    logic                  grant;
    logic [NUM_PORTS-1:0]  head_valid;
    logic [NUM_PORTS-1:0]  ack;
    mem_req_t              chosen;

    assign head_valid = {head_valid1, head_valid0};

    always_comb
    begin
        if (&head_valid)
        begin
            // both waiting, the port that lost last time goes
            winner = (last_winner == GRANT_PORT0) ? GRANT_PORT1 : GRANT_PORT0;
        end
        else if (head_valid[1])
        begin
            winner = GRANT_PORT1;
        end
        else
        begin
            winner = GRANT_PORT0;
        end
    end

    assign grant      = (|head_valid) & ~mem_hold;
    assign ack[0]     = grant & (winner == GRANT_PORT0);
    assign ack[1]     = grant & (winner == GRANT_PORT1);
    assign issue_ack0 = ack[0];
    assign issue_ack1 = ack[1];

    assign chosen = (winner == GRANT_PORT1) ? head1 : head0;

    assign grant_bus.valid  = grant;
    assign grant_bus.opcode = chosen.opcode;
    assign grant_bus.addr   = chosen.addr;
    assign grant_bus.data   = chosen.data;
    assign grant_bus.port   = winner;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            // port 0 first out of reset
            last_winner <= GRANT_PORT1;
        end
        else if (grant)
        begin
            last_winner <= winner;
        end
    end

    one_ack: assert property (
        @(posedge clk_in) disable iff (reset_in)
        $onehot0(ack)
    )
    else
    begin
        $error("request_arbiter: both ports acked");
    end

    // port 0 never wins twice running while port 1 waits
    port0_yields: assert property (
        @(posedge clk_in) disable iff (reset_in)
        ack[0] |=> !(ack[0] && head_valid[1])
    )
    else
    begin
        $error("request_arbiter: port 1 starved");
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, status follows the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mem_subsystem \
    -f build.f -o sim_tb || exit 1
sim_out=$(./obj_dir/sim_tb)
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation PASSED" && echo "run_sim: pass" || {
    echo "run_sim: fail"
    exit 1
}

// ==== shared_memory_unit.sv ====
`timescale 1ns/1ps

module shared_memory_unit
    import mem_pkg::*;
(
    input  logic                   clk_in,
    input  logic                   reset_in,

    mem_req_if.mem                 grant_bus,

    output logic                   resp_valid,
    output grant_e                 resp_port,
    output logic [DATA_WIDTH-1:0]  resp_data
);

    localparam int MASK_LEN = mask_len(DATA_WIDTH);

    logic                   do_write;
    logic                   do_read;
    logic [DATA_WIDTH-1:0]  read_word;

    assign do_write = grant_bus.valid & (grant_bus.opcode == OP_WRITE);
    assign do_read  = grant_bus.valid & (grant_bus.opcode == OP_READ);

    // one request per cycle, so both ports share the granted address
    dual_port_lutram
    #(
        .ENTRY_WIDTH (DATA_WIDTH),
        .NUM_SET     (MEM_DEPTH)
    )
    mem_array
    (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .write_en    ({MASK_LEN{do_write}}),
        .write_addr  (grant_bus.addr),
        .write_data  (grant_bus.data),
        .read_addr   (grant_bus.addr),
        .read_data   (read_word)
    );

    // response pulse the cycle after the grant
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            resp_valid <= 1'b0;
        end
        else
        begin
            resp_valid <= do_read;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (do_read)
        begin
            resp_data <= read_word;
            resp_port <= grant_bus.port;
        end
    end

endmodule

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem
    import mem_pkg::*;
();

    typedef struct {
        int                     test;
        grant_e                 port;
        mem_opcode_e            opcode;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [DATA_WIDTH-1:0]  data;
        logic                   hold;
    } row_t;

    // request sitting in a queue, with the edge that accepted it
    typedef struct {
        grant_e                 port;
        mem_opcode_e            opcode;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [DATA_WIDTH-1:0]  data;
        int                     accept_edge;
    } pending_t;

    typedef struct {
        grant_e                 port;
        logic [DATA_WIDTH-1:0]  data;
    } expect_t;

    logic                   clk_in;
    logic                   reset_in;
    logic                   req_valid_0;
    mem_opcode_e            req_opcode_0;
    logic [ADDR_WIDTH-1:0]  req_addr_0;
    logic [DATA_WIDTH-1:0]  req_data_0;
    logic                   req_ack_0;
    logic                   req_valid_1;
    mem_opcode_e            req_opcode_1;
    logic [ADDR_WIDTH-1:0]  req_addr_1;
    logic [DATA_WIDTH-1:0]  req_data_1;
    logic                   req_ack_1;
    logic                   mem_hold;
    logic                   resp_valid;
    grant_e                 resp_port;
    logic [DATA_WIDTH-1:0]  resp_data;

    int                     seed;
    int                     error_count;
    int                     test_errors;
    int                     tests_passed;
    int                     tests_failed;
    int                     edge_count;
    logic                   table_ready;
    logic                   resp_expected;
    grant_e                 model_last;
    int                     last_grant [NUM_PORTS];
    logic [DATA_WIDTH-1:0]  model_mem [MEM_DEPTH];
    row_t                   rows [$];
    pending_t               pend_q [$];
    expect_t                exp_q [$];

    mem_subsystem_top UUT
    (
        .clk_in (clk_in), .reset_in (reset_in),
        .req_valid_0 (req_valid_0), .req_opcode_0 (req_opcode_0),
        .req_addr_0 (req_addr_0), .req_data_0 (req_data_0), .req_ack_0 (req_ack_0),
        .req_valid_1 (req_valid_1), .req_opcode_1 (req_opcode_1),
        .req_addr_1 (req_addr_1), .req_data_1 (req_data_1), .req_ack_1 (req_ack_1),
        .mem_hold (mem_hold),
        .resp_valid (resp_valid), .resp_port (resp_port), .resp_data (resp_data)
    );

    always
    begin
        #2 clk_in = ~clk_in;
    end

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_data(input string what, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            note_error();
        end
    endtask

    task automatic check_port(input string what, input grant_e got, input grant_e exp);
        if (got !== exp)
        begin
            $display("ERR %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
            note_error();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            note_error();
        end
    endtask

    task automatic add_row(input int test, input grant_e port, input mem_opcode_e op,
                           input logic [ADDR_WIDTH-1:0] addr, input logic hold);
        row_t r;
        r = '{test: test, port: port, opcode: op, addr: addr, data: $random(seed), hold: hold};
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        add_row(2, GRANT_PORT0, OP_WRITE, 8'h10, 1'b0);
        add_row(2, GRANT_PORT0, OP_READ,  8'h10, 1'b0);
        add_row(2, GRANT_PORT1, OP_WRITE, 8'h20, 1'b0);
        add_row(2, GRANT_PORT1, OP_READ,  8'h20, 1'b0);
        // five per port under hold, the fifth finds the queue full
        add_row(3, GRANT_PORT0, OP_WRITE, 8'h30, 1'b1);
        add_row(3, GRANT_PORT0, OP_READ,  8'h30, 1'b1);
        add_row(3, GRANT_PORT0, OP_READ,  8'h10, 1'b1);
        add_row(3, GRANT_PORT0, OP_WRITE, 8'h31, 1'b1);
        add_row(3, GRANT_PORT0, OP_READ,  8'h31, 1'b1);
        add_row(3, GRANT_PORT1, OP_WRITE, 8'h38, 1'b1);
        add_row(3, GRANT_PORT1, OP_READ,  8'h38, 1'b1);
        add_row(3, GRANT_PORT1, OP_READ,  8'h20, 1'b1);
        add_row(3, GRANT_PORT1, OP_READ,  8'h30, 1'b1);
        add_row(3, GRANT_PORT1, OP_READ,  8'h38, 1'b1);
        add_row(4, GRANT_PORT0, OP_READ,  8'h10, 1'b1);
        add_row(4, GRANT_PORT1, OP_READ,  8'h20, 1'b1);
        add_row(4, GRANT_PORT0, OP_READ,  8'h30, 1'b1);
        add_row(4, GRANT_PORT1, OP_READ,  8'h38, 1'b1);
        add_row(4, GRANT_PORT0, OP_READ,  8'h31, 1'b1);
        add_row(4, GRANT_PORT1, OP_READ,  8'h10, 1'b1);
        add_row(5, GRANT_PORT1, OP_WRITE, 8'h50, 1'b0);
        add_row(5, GRANT_PORT0, OP_WRITE, 8'h50, 1'b1);
        add_row(5, GRANT_PORT1, OP_READ,  8'h50, 1'b1);
        add_row(5, GRANT_PORT0, OP_READ,  8'h50, 1'b1);
        // prime the random window so no read sees an unwritten word
        for (int i = 0; i < 8; i++)
            add_row(6, (i % 2 == 1) ? GRANT_PORT1 : GRANT_PORT0, OP_WRITE,
                    ADDR_WIDTH'(8'h40 + i), 1'b0);
        for (int i = 0; i < 24; i++)
        begin
            rnd = $random(seed);
            add_row(6, rnd[0] ? GRANT_PORT1 : GRANT_PORT0, rnd[1] ? OP_WRITE : OP_READ,
                    8'h40 + {5'd0, rnd[4:2]}, (i >= 4) && (rnd[6:5] == 2'b00));
        end
    endtask

    function automatic int find_head(input grant_e p);
        for (int i = 0; i < pend_q.size(); i++)
            if (pend_q[i].port == p)
                return i;
        return -1;
    endfunction

    function automatic int pending_count(input grant_e p);
        int n;
        n = 0;
        foreach (pend_q[i])
            if (pend_q[i].port == p)
                n++;
        return n;
    endfunction

    // head grantable two edges after accept, one edge after the previous grant
    function automatic logic head_ready(input grant_e p);
        int idx;
        int ready;
        idx = find_head(p);
        if (idx < 0)
            return 1'b0;
        ready = pend_q[idx].accept_edge + 2;
        if (last_grant[p] + 1 > ready)
            ready = last_grant[p] + 1;
        return ready <= edge_count;
    endfunction

    task automatic grant_head(input grant_e p);
        int       idx;
        pending_t head;
        expect_t  e;
        idx = find_head(p);
        head = pend_q[idx];
        pend_q.delete(idx);
        last_grant[p] = edge_count;
        model_last = p;
        if (head.opcode == OP_WRITE)
            model_mem[head.addr] = head.data;
        else
        begin
            e = '{port: p, data: model_mem[head.addr]};
            exp_q.push_back(e);
            resp_expected = 1'b1;
        end
    endtask

    task automatic take_response();
        if (exp_q.size() == 0)
        begin
            $display("response on port %s at %0t with no read outstanding",
                     resp_port.name(), $time);
            note_error();
        end
        else
        begin
            check_port("resp_port", resp_port, exp_q[0].port);
            check_data("resp_data", resp_data, exp_q[0].data);
            exp_q.delete(0);
        end
    endtask

    // called mid low phase, predicts the coming rising edge
    task automatic predict_edge();
        logic     ack0;
        logic     ack1;
        logic     ready0;
        logic     ready1;
        grant_e   winner;
        pending_t accepted;
        check_flag("resp_valid", resp_valid, resp_expected);
        if (resp_valid)
            take_response();
        resp_expected = 1'b0;
        ack0 = pending_count(GRANT_PORT0) < QUEUE_DEPTH;
        ack1 = pending_count(GRANT_PORT1) < QUEUE_DEPTH;
        ready0 = head_ready(GRANT_PORT0);
        ready1 = head_ready(GRANT_PORT1);
        if (!mem_hold && (ready0 || ready1))
        begin
            if (ready0 && ready1)
                winner = (model_last == GRANT_PORT0) ? GRANT_PORT1 : GRANT_PORT0;
            else
                winner = ready1 ? GRANT_PORT1 : GRANT_PORT0;
            grant_head(winner);
            ack0 = ack0 | (winner == GRANT_PORT0);
            ack1 = ack1 | (winner == GRANT_PORT1);
        end
        check_flag("req_ack_0", req_ack_0, ack0);
        check_flag("req_ack_1", req_ack_1, ack1);
        if (req_valid_0 && ack0)
        begin
            accepted = '{GRANT_PORT0, req_opcode_0, req_addr_0, req_data_0, edge_count};
            pend_q.push_back(accepted);
        end
        if (req_valid_1 && ack1)
        begin
            accepted = '{GRANT_PORT1, req_opcode_1, req_addr_1, req_data_1, edge_count};
            pend_q.push_back(accepted);
        end
        edge_count++;
    endtask

    task automatic run_cycle(input logic active, input row_t r);
        @(negedge clk_in);
        req_valid_0 = active && (r.port == GRANT_PORT0);
        req_valid_1 = active && (r.port == GRANT_PORT1);
        req_opcode_0 = r.opcode;
        req_opcode_1 = r.opcode;
        req_addr_0 = r.addr;
        req_addr_1 = r.addr;
        req_data_0 = r.data;
        req_data_1 = r.data;
        mem_hold = r.hold;
        #1;
        predict_edge();
    endtask

    task automatic idle_cycle();
        row_t r;
        r = '{test: 0, port: GRANT_PORT0, opcode: OP_READ, addr: '0, data: '0, hold: 1'b0};
        run_cycle(1'b0, r);
    endtask

    // hold released, wait for every queued request and response
    task automatic drain();
        while (pend_q.size() > 0 || exp_q.size() > 0)
            idle_cycle();
        idle_cycle();
    endtask

    task automatic finish_test(input int t, input string title);
        if (test_errors == 0)
        begin
            tests_passed++;
            $display("test %0d %s: ok", t, title);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d mismatches", t, title, test_errors);
        end
    endtask

    initial
    begin
        wait (table_ready);
        #(rows.size() * 20 * 4);
        $display("timeout: responses missing");
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        string titles [7];
        titles = '{"", "reset state", "write then read", "hold and full",
                   "alternation", "cross-port read", "random mix"};
        clk_in = 1'b0;
        reset_in = 1'b1;
        req_valid_0 = 1'b0;
        req_valid_1 = 1'b0;
        req_opcode_0 = OP_READ;
        req_opcode_1 = OP_READ;
        req_addr_0 = '0;
        req_addr_1 = '0;
        req_data_0 = '0;
        req_data_1 = '0;
        mem_hold = 1'b0;
        seed = 52394;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        edge_count = 0;
        resp_expected = 1'b0;
        model_last = GRANT_PORT1;
        last_grant = '{-10, -10};
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(negedge clk_in);
        reset_in = 1'b0;

        test_errors = 0;
        idle_cycle();
        check_flag("resp_valid after reset", resp_valid, 1'b0);
        check_flag("req_ack_0 after reset", req_ack_0, 1'b1);
        check_flag("req_ack_1 after reset", req_ack_1, 1'b1);
        finish_test(1, titles[1]);

        for (int t = 2; t <= 6; t++)
        begin
            test_errors = 0;
            foreach (rows[i])
                if (rows[i].test == t)
                    run_cycle(1'b1, rows[i]);
            drain();
            finish_test(t, titles[t]);
        end

        $display("tests passed %0d failed %0d, %0d mismatches in total",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
